// ==== hdl/bitbang_consts.svh ====
`ifndef BITBANG_CONSTS_SVH
`define BITBANG_CONSTS_SVH

// control pattern from the host
// loads the data word and raises active
`define BB_ON_PATTERN 16'hFAB1

// control pattern that drops active again
`define BB_OFF_PATTERN 16'hFAB0

// data word, shifted on rising s_clk
`define BB_DATA_W 32

// control word, shifted on falling s_clk
`define BB_CTRL_W 16

// sampling stages per pin
// edges are seen between the two oldest stages
`define BB_SYNC_DEPTH 4

// configuration registers behind the port
`define CFG_NUM_REGS 8

`endif

// ==== hdl/bitbang_pkg.sv ====
`include "bitbang_consts.svh"

package bitbang_pkg;

  // data word as collected on rising s_clk edges
  // first bit received ends up in the msb
  typedef logic [`BB_DATA_W-1:0] bb_word_t;

  // control word as collected on falling s_clk edges
  // compared against the on and off patterns
  typedef logic [`BB_CTRL_W-1:0] bb_ctrl_t;

endpackage

// ==== hdl/cfg_pkg.sv ====
`include "bitbang_consts.svh"

package cfg_pkg;

  // register index
  typedef logic [$clog2(`CFG_NUM_REGS)-1:0] cfg_addr_t;

  // register contents
  typedef logic [15:0] cfg_data_t;

  // command view of a received 32-bit word
  typedef struct packed {
    // 1 = write, 0 = read
    logic       wr;
    // reserved, ignored
    logic [3:0] rsvd;
    cfg_addr_t  addr;
    // ignored
    logic [7:0] ign;
    // write value, don't care on reads
    cfg_data_t  value;
  } cfg_cmd_t;

endpackage

// ==== hdl/bitbang_rx.sv ====
`timescale 1ns/1ps
`include "bitbang_consts.svh"

module bitbang_rx import bitbang_pkg::*; (
  input  logic     clk,
  input  logic     resetn,
  input  logic     s_clk,
  input  logic     s_data,
  output bb_word_t word,
  output logic     word_strobe,
  output logic     active,
  output logic     sclk_rise
);

  localparam int unsigned SYNC_MSB = `BB_SYNC_DEPTH - 1;

  // sampling chains, oldest sample in the msb
  logic [SYNC_MSB:0] s_clk_sample;
  logic [SYNC_MSB:0] s_data_sample;

  logic sclk_fall;

  // shift registers fed from the same data pin
  bb_word_t serial_data;
  bb_ctrl_t serial_control;

  logic on_match;
  logic off_match;

  // raw match level and its delayed copy
  logic local_strobe;
  logic old_local_strobe;

  // pins are asynchronous to clk
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      s_clk_sample  <= '0;
      s_data_sample <= '0;
    end else begin
      s_clk_sample  <= {s_clk_sample[SYNC_MSB-1:0], s_clk};
      s_data_sample <= {s_data_sample[SYNC_MSB-1:0], s_data};
    end
  end

  // edge events between the two oldest s_clk stages
  assign sclk_rise = !s_clk_sample[SYNC_MSB] && s_clk_sample[SYNC_MSB-1];
  assign sclk_fall = s_clk_sample[SYNC_MSB] && !s_clk_sample[SYNC_MSB-1];

  // data bits on rising edges, control bits on falling edges
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      serial_data    <= '0;
      serial_control <= '0;
    end else begin
      if (sclk_rise) begin
        serial_data <= {serial_data[`BB_DATA_W-2:0], s_data_sample[SYNC_MSB]};
      end
      if (sclk_fall) begin
        // same pin, sampled half a period later
        serial_control <= {serial_control[`BB_CTRL_W-2:0], s_data_sample[SYNC_MSB]};
      end
    end
  end

  assign on_match  = (serial_control == bb_ctrl_t'(`BB_ON_PATTERN));
  assign off_match = (serial_control == bb_ctrl_t'(`BB_OFF_PATTERN));

  // word follows the data shifter while on matches
  // only the strobe cycle is guaranteed to hold the frame
  always_ff @(posedge clk) begin
    if (on_match) begin
      word <= serial_data;
    end
  end

  // match level lasts until the next falling edge
  // strobe fires on its first cycle only
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      local_strobe     <= 1'b0;
      old_local_strobe <= 1'b0;
      word_strobe      <= 1'b0;
    end else begin
      local_strobe     <= on_match;
      old_local_strobe <= local_strobe;
      word_strobe      <= local_strobe && !old_local_strobe;
    end
  end

  // port enable level
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      active <= 1'b0;
    end else if (on_match) begin
      active <= 1'b1;
    end else if (off_match) begin
      active <= 1'b0;
    end
  end

endmodule

// ==== hdl/cfg_reg_bank.sv ====
`timescale 1ns/1ps
`include "bitbang_consts.svh"

module cfg_reg_bank import bitbang_pkg::*, cfg_pkg::*; (
  input  logic      clk,
  input  logic      resetn,
  input  bb_word_t  word,
  input  logic      word_strobe,
  output cfg_data_t cfg_q [`CFG_NUM_REGS],
  output logic      rd_load,
  output cfg_data_t rd_value
);

  // received word seen as a command
  cfg_cmd_t cmd;

  logic wr_en;
  logic rd_en;

  assign cmd = cfg_cmd_t'(word);

  // word is only valid together with the strobe
  assign wr_en = word_strobe && cmd.wr;
  assign rd_en = word_strobe && !cmd.wr;

  // register array
  // holds its value between write commands
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      for (int i = 0; i < `CFG_NUM_REGS; i++) begin
        cfg_q[i] <= '0;
      end
    end else if (wr_en) begin
      cfg_q[cmd.addr] <= cmd.value;
    end
  end

  // read side
  // rd_load is a single pulse, the value is captured with it
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      rd_load  <= 1'b0;
      rd_value <= '0;
    end else begin
      rd_load <= rd_en;
      if (rd_en) begin
        rd_value <= cfg_q[cmd.addr];
      end
    end
  end

endmodule

// ==== hdl/bitbang_readback.sv ====
`timescale 1ns/1ps

module bitbang_readback import cfg_pkg::*; (
  input  logic      clk,
  input  logic      resetn,
  input  logic      rd_load,
  input  logic      sclk_rise,
  input  logic      active,
  input  cfg_data_t rd_value,
  output logic      s_dout
);

  localparam int unsigned SHIFT_W = $bits(cfg_data_t);

  // parallel load, serial out, msb first
  logic [SHIFT_W-1:0] shift_q;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      shift_q <= '0;
    end else if (rd_load) begin
      // a new read drops whatever was still going out
      shift_q <= rd_value;
    end else if (sclk_rise) begin
      // one bit per host clock period, zeros fill from below
      shift_q <= {shift_q[SHIFT_W-2:0], 1'b0};
    end
  end

  // pin stays low while the port is off
  assign s_dout = active && shift_q[SHIFT_W-1];

endmodule

// ==== hdl/bitbang_cfg_top.sv ====
`timescale 1ns/1ps
`include "bitbang_consts.svh"

module bitbang_cfg_top import bitbang_pkg::*, cfg_pkg::*; (
  input  logic      clk,
  input  logic      resetn,
  input  logic      s_clk,
  input  logic      s_data,
  output logic      active,
  output logic      s_dout,
  output cfg_data_t cfg_q [`CFG_NUM_REGS]
);

  // receiver to register bank
  bb_word_t  word;
  logic      word_strobe;

  // receiver to readback
  logic      sclk_rise;

  // register bank to readback
  logic      rd_load;
  cfg_data_t rd_value;

  // pin sampling, shifters and pattern match
  bitbang_rx i_rx (
    .clk         (clk),
    .resetn      (resetn),
    .s_clk       (s_clk),
    .s_data      (s_data),
    .word        (word),
    .word_strobe (word_strobe),
    .active      (active),
    .sclk_rise   (sclk_rise)
  );

  // command decode and configuration registers
  cfg_reg_bank i_bank (
    .clk         (clk),
    .resetn      (resetn),
    .word        (word),
    .word_strobe (word_strobe),
    .cfg_q       (cfg_q),
    .rd_load     (rd_load),
    .rd_value    (rd_value)
  );

  // read data back out on s_dout, paced by the host clock
  bitbang_readback i_readback (
    .clk       (clk),
    .resetn    (resetn),
    .rd_load   (rd_load),
    .sclk_rise (sclk_rise),
    .active    (active),
    .rd_value  (rd_value),
    .s_dout    (s_dout)
  );

endmodule

// ==== dv/tb_bitbang_cfg.sv ====
`timescale 1ns/1ps
`include "bitbang_consts.svh"

module tb_bitbang_cfg import bitbang_pkg::*, cfg_pkg::*; ();

  // one s_clk level is two halves of this many clk cycles
  localparam int HALF_LEVEL     = 5;
  localparam int IDLE_CYCLES    = 10;
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int NUM_WRITES     = 40;
  localparam int NUM_NOISE      = 12;
  localparam int RD_W           = $bits(cfg_data_t);

  logic      clk;
  logic      resetn;
  logic      s_clk;
  logic      s_data;
  logic      active;
  logic      s_dout;
  cfg_data_t cfg_q [`CFG_NUM_REGS];

  // reference model of the register map
  cfg_data_t model_regs [`CFG_NUM_REGS];
  bit        exp_active;

  int error_count;
  int check_count;

  // driver to compare process handshake
  int check_seq;
  int done_seq;
  bit run_done;

  bitbang_cfg_top i_dut (
    .clk    (clk),
    .resetn (resetn),
    .s_clk  (s_clk),
    .s_data (s_data),
    .active (active),
    .s_dout (s_dout),
    .cfg_q  (cfg_q)
  );

  // 10 ns clock
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // expected outcome of one command word
  // write updates the model copy and read returns the addressed value
  function automatic cfg_data_t apply_cmd(input bb_word_t cmd_word);
    logic      is_write;
    cfg_addr_t addr;
    cfg_data_t value;
    // bit 31 write flag, 26:24 address, 15:0 value
    is_write = cmd_word[31];
    addr     = cmd_word[26:24];
    value    = cmd_word[15:0];
    if (is_write) begin
      model_regs[addr] = value;
    end
    return model_regs[addr];
  endfunction

  // reserved and ignored fields get random junk
  function automatic bb_word_t make_cmd(input logic is_write, input cfg_addr_t addr,
                                        input cfg_data_t value);
    bb_word_t w;
    w        = bb_word_t'($urandom());
    w[31]    = is_write;
    w[26:24] = addr;
    w[15:0]  = value;
    return w;
  endfunction

  // no shifted copy may look like on or off
  // while it is pushed out by the next frame
  function automatic bit pattern_is_neutral(input bb_ctrl_t p);
    bb_ctrl_t shifted;
    if (p == `BB_ON_PATTERN || p == `BB_OFF_PATTERN) begin
      return 1'b0;
    end
    for (int k = 1; k < `BB_CTRL_W; k++) begin
      shifted = p << k;
      if (shifted == `BB_ON_PATTERN || shifted == `BB_OFF_PATTERN) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  function automatic bb_ctrl_t pick_noise_pattern();
    bb_ctrl_t p;
    for (int tries = 0; tries < 100; tries++) begin
      p = bb_ctrl_t'($urandom());
      if (pattern_is_neutral(p)) begin
        return p;
      end
    end
    // fallback value is neutral as well
    return 16'h1234;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic abort_run(input string reason);
    error_count++;
    $display("Timeout at %0t: %s", $time, reason);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    $display("Regression failed");
    $finish;
  endtask

  // pins always move 1 ns after a rising clk edge
  task automatic advance_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // one frame of 32 s_clk periods
  // data bit ahead of each rising edge and control bit ahead of each falling edge
  task automatic send_frame(input bb_word_t data_word, input bb_ctrl_t pattern);
    logic ctrl_bit;
    for (int i = 0; i < `BB_DATA_W; i++) begin
      // falling edge with the previous control bit still on the pin
      s_clk = 1'b0;
      advance_cycles(HALF_LEVEL);
      s_data = data_word[`BB_DATA_W-1-i];
      advance_cycles(HALF_LEVEL);
      s_clk = 1'b1;
      advance_cycles(HALF_LEVEL);
      // only the last 16 periods carry the pattern
      if (i >= `BB_DATA_W - `BB_CTRL_W) begin
        ctrl_bit = pattern[`BB_DATA_W-1-i];
      end else begin
        ctrl_bit = 1'b0;
      end
      s_data = ctrl_bit;
      advance_cycles(HALF_LEVEL);
    end
    // final falling edge completes the control word
    s_clk = 1'b0;
    advance_cycles(HALF_LEVEL);
    s_data = 1'b0;
  endtask

  // 16 idle periods with s_dout taken just before each rising edge
  task automatic read_bits(output cfg_data_t bits);
    bits   = '0;
    s_data = 1'b0;
    for (int i = 0; i < RD_W; i++) begin
      s_clk = 1'b0;
      advance_cycles(2 * HALF_LEVEL);
      bits[RD_W-1-i] = s_dout;
      s_clk = 1'b1;
      advance_cycles(2 * HALF_LEVEL);
    end
    s_clk = 1'b0;
    advance_cycles(2 * HALF_LEVEL);
  endtask

  // hand the current model to the compare process and wait for it
  task automatic request_compare();
    int waited;
    waited = 0;
    check_seq++;
    while (done_seq != check_seq) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        abort_run("compare process did not answer a check request");
      end
    end
  endtask

  task automatic idle_and_compare();
    advance_cycles(IDLE_CYCLES);
    request_compare();
  endtask

  task automatic compare_model();
    string name;
    for (int i = 0; i < `CFG_NUM_REGS; i++) begin
      name = $sformatf("cfg_q[%0d]", i);
      check_value(name, cfg_q[i], model_regs[i]);
    end
    check_value("active", active, exp_active);
  endtask

  // compares the outputs against the model on request
  initial begin : compare_proc
    int waited;
    forever begin
      waited = 0;
      while (done_seq == check_seq && !run_done) begin
        @(posedge clk);
        waited++;
        if (waited > TIMEOUT_CYCLES) begin
          abort_run("no check request from the host driver");
        end
      end
      if (run_done) begin
        break;
      end
      // outputs have been quiet through the idle time
      compare_model();
      done_seq = check_seq;
    end
  end

  initial begin : stimulus
    bb_word_t  cmd_word;
    bb_ctrl_t  noise;
    cfg_data_t rd_exp;
    cfg_data_t rd_got;

    void'($urandom(32'h95e0_cf66));
    resetn     = 1'b0;
    s_clk      = 1'b0;
    s_data     = 1'b0;
    exp_active = 1'b0;
    for (int i = 0; i < `CFG_NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    advance_cycles(3);
    resetn = 1'b1;
    advance_cycles(2);

    // out of reset
    check_value("active", active, 1'b0);
    check_value("s_dout", s_dout, 1'b0);
    request_compare();

    // random writes under the on pattern
    for (int n = 0; n < NUM_WRITES; n++) begin
      cmd_word = make_cmd(1'b1, cfg_addr_t'($urandom_range(`CFG_NUM_REGS-1, 0)),
                          cfg_data_t'($urandom()));
      send_frame(cmd_word, `BB_ON_PATTERN);
      void'(apply_cmd(cmd_word));
      exp_active = 1'b1;
      idle_and_compare();
    end

    // read every register back over s_dout
    for (int r = 0; r < `CFG_NUM_REGS; r++) begin
      cmd_word = make_cmd(1'b0, cfg_addr_t'(r), cfg_data_t'($urandom()));
      send_frame(cmd_word, `BB_ON_PATTERN);
      rd_exp = apply_cmd(cmd_word);
      idle_and_compare();
      read_bits(rd_got);
      check_value($sformatf("s_dout readback of cfg_q[%0d]", r), rd_got, rd_exp);
    end

    // write commands under a wrong pattern
    // model and active must stay as they are
    for (int n = 0; n < NUM_NOISE; n++) begin
      noise    = pick_noise_pattern();
      cmd_word = make_cmd(1'b1, cfg_addr_t'($urandom_range(`CFG_NUM_REGS-1, 0)),
                          cfg_data_t'($urandom()));
      send_frame(cmd_word, noise);
      idle_and_compare();
    end

    // off pattern drops active and leaves the registers alone
    cmd_word = make_cmd(1'b1, cfg_addr_t'($urandom_range(`CFG_NUM_REGS-1, 0)),
                        cfg_data_t'($urandom()));
    send_frame(cmd_word, `BB_OFF_PATTERN);
    exp_active = 1'b0;
    idle_and_compare();
    read_bits(rd_got);
    check_value("s_dout while inactive", rd_got, '0);

    // read with on pattern brings the port back
    cmd_word = make_cmd(1'b0, cfg_addr_t'($urandom_range(`CFG_NUM_REGS-1, 0)),
                        cfg_data_t'($urandom()));
    send_frame(cmd_word, `BB_ON_PATTERN);
    rd_exp     = apply_cmd(cmd_word);
    exp_active = 1'b1;
    idle_and_compare();
    read_bits(rd_got);
    check_value("s_dout readback after reactivation", rd_got, rd_exp);

    run_done = 1'b1;
    advance_cycles(2);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+hdl
hdl/bitbang_pkg.sv
hdl/cfg_pkg.sv
hdl/bitbang_rx.sv
hdl/cfg_reg_bank.sv
hdl/bitbang_readback.sv
hdl/bitbang_cfg_top.sv
dv/tb_bitbang_cfg.sv

// ==== Bender.yml ====
package:
  name: bitbang_cfg

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/bitbang_pkg.sv
      - hdl/cfg_pkg.sv
      - hdl/bitbang_rx.sv
      - hdl/cfg_reg_bank.sv
      - hdl/bitbang_readback.sv
      - hdl/bitbang_cfg_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/tb_bitbang_cfg.sv
